//--- mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;

	// Bus positions of the two requesters
	typedef logic port_idx_t;
	localparam port_idx_t PORT_INSN = 1'b0;
	localparam port_idx_t PORT_DATA = 1'b1;

	typedef struct packed
	{
		logic [addr_w-1:0] addr;
	} insn_req_t;

	typedef struct packed
	{
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic wr; // Set for a store
	} data_req_t;

	typedef struct packed
	{
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic wr;
		port_idx_t port; // Requester the read data goes back to
	} ram_cmd_t;

	typedef struct packed
	{
		logic [data_w-1:0] rdata;
		port_idx_t port;
	} resp_t;

endpackage

`default_nettype wire

//--- credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter int FIFO_DEPTH = 4,
	parameter type item_t = logic
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input item_t in_item,
	output logic head_valid,
	output item_t head_item,
	input logic head_pop,
	output logic credit
);

	localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int cnt_w = $clog2(FIFO_DEPTH + 1);
	localparam logic [ptr_w-1:0] last_slot = ptr_w'(FIFO_DEPTH - 1);

	item_t buf_mem [FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_pop;

	assign head_valid = (count != '0);
	assign head_item = buf_mem[rd_ptr];
	assign do_pop = head_pop & head_valid;
	assign credit = do_pop; // A freed slot lets the requester send one more

	always_ff @(posedge clk)
	begin
		if (in_valid)
			buf_mem[wr_ptr] <= in_item;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			if (in_valid && !do_pop)
				count <= count + 1'b1;
			else if (!in_valid && do_pop)
				count <= count - 1'b1;
		end
	end

	// A full queue means the requester has spent all of its credits
	assert property (@(posedge clk) disable iff (rst) in_valid |-> count != cnt_w'(FIFO_DEPTH))
		else $error("credit_fifo: request strobed without a credit");

	// The arbiter must only grant a head that is there
	assert property (@(posedge clk) disable iff (rst) head_pop |-> head_valid)
		else $error("credit_fifo: pop from an empty queue");

endmodule

`default_nettype wire

//--- bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input logic clk,
	input logic rst,
	input logic insn_head_valid,
	input mem_sys_pkg::insn_req_t insn_head,
	input logic data_head_valid,
	input mem_sys_pkg::data_req_t data_head,
	input logic [1:0] read_room,
	output logic insn_pop,
	output logic data_pop,
	output logic cmd_valid,
	output mem_sys_pkg::ram_cmd_t cmd
);

	import mem_sys_pkg::*;

	port_idx_t last_port;
	logic insn_elig;
	logic data_elig;

	assign insn_elig = insn_head_valid & read_room[PORT_INSN];
	assign data_elig = data_head_valid & (data_head.wr | read_room[PORT_DATA]); // Stores need no room

	// On a tie the port served last steps aside
	assign data_pop = data_elig & (!insn_elig | (last_port == PORT_INSN));
	assign insn_pop = insn_elig & (!data_elig | (last_port == PORT_DATA));
	assign cmd_valid = insn_pop | data_pop;

	always_comb
	begin
		if (data_pop)
		begin
			cmd.addr = data_head.addr;
			cmd.wdata = data_head.wdata;
			cmd.wr = data_head.wr;
			cmd.port = PORT_DATA;
		end
		else
		begin
			cmd.addr = insn_head.addr; // Instruction fetches are always reads
			cmd.wdata = '0;
			cmd.wr = 1'b0;
			cmd.port = PORT_INSN;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			last_port <= PORT_DATA;
		else if (cmd_valid)
			last_port <= cmd.port;
	end

	// The single RAM port takes one command per cycle
	assert property (@(posedge clk) disable iff (rst) !(insn_pop && data_pop))
		else $error("bus_arbiter: both queues popped in one cycle");

endmodule

`default_nettype wire

//--- block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram #(
	parameter int RAM_WORDS = 256
) (
	input logic clk,
	input logic cmd_valid,
	input mem_sys_pkg::ram_cmd_t cmd,
	output logic [mem_sys_pkg::data_w-1:0] rdata
);

	import mem_sys_pkg::*;

	localparam int idx_w = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	logic [data_w-1:0] mem [RAM_WORDS];
	logic [idx_w-1:0] word_idx;

	assign word_idx = cmd.addr[idx_w+1:2]; // Drop the byte offset

	// A single port means a cycle either writes or reads
	always_ff @(posedge clk)
	begin
		if (cmd_valid)
		begin
			if (cmd.wr)
				mem[word_idx] <= cmd.wdata;
			else
				rdata <= mem[word_idx];
		end
	end

endmodule

`default_nettype wire

//--- resp_router.sv
`timescale 1ns/1ps
`default_nettype none

module resp_router #(
	parameter int RESP_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input mem_sys_pkg::ram_cmd_t cmd,
	input logic [mem_sys_pkg::data_w-1:0] rdata,
	output logic [1:0] read_room,
	input logic insn_resp_credit,
	input logic data_resp_credit,
	output logic insn_resp_valid,
	output logic data_resp_valid,
	output mem_sys_pkg::resp_t resp
);

	import mem_sys_pkg::*;

	localparam int cnt_w = $clog2(RESP_CREDITS + 1);

	logic [cnt_w-1:0] cnt [2];
	logic [1:0] rd_grant;
	logic [1:0] credit_in;
	logic rd_pending;
	port_idx_t rd_port;

	// A read takes the consumer credit at grant time
	assign rd_grant[PORT_INSN] = cmd_valid & !cmd.wr & (cmd.port == PORT_INSN);
	assign rd_grant[PORT_DATA] = cmd_valid & !cmd.wr & (cmd.port == PORT_DATA);
	assign credit_in[PORT_INSN] = insn_resp_credit;
	assign credit_in[PORT_DATA] = data_resp_credit;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt[0] <= cnt_w'(RESP_CREDITS);
			cnt[1] <= cnt_w'(RESP_CREDITS);
			rd_pending <= 1'b0;
			rd_port <= PORT_INSN;
		end
		else
		begin
			for (int p = 0; p < 2; p++)
				cnt[p] <= cnt[p] + cnt_w'(credit_in[p]) - cnt_w'(rd_grant[p]);
			rd_pending <= |rd_grant;
			rd_port <= cmd.port; // Only looked at when rd_pending is set
		end
	end

	assign read_room[0] = (cnt[0] != '0);
	assign read_room[1] = (cnt[1] != '0);

	assign insn_resp_valid = rd_pending & (rd_port == PORT_INSN);
	assign data_resp_valid = rd_pending & (rd_port == PORT_DATA);
	assign resp.rdata = rdata;
	assign resp.port = rd_port;

	// More credits than granted means a consumer returned one twice
	assert property (@(posedge clk) disable iff (rst) cnt[0] <= cnt_w'(RESP_CREDITS))
		else $error("resp_router: instruction consumer credit overflow");
	assert property (@(posedge clk) disable iff (rst) cnt[1] <= cnt_w'(RESP_CREDITS))
		else $error("resp_router: data consumer credit overflow");

endmodule

`default_nettype wire

//--- mem_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int RAM_WORDS = 256,
	parameter int RESP_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input mem_sys_pkg::insn_req_t insn_req,
	output logic insn_credit,
	input logic data_valid,
	input mem_sys_pkg::data_req_t data_req,
	output logic data_credit,
	output logic insn_resp_valid,
	output logic data_resp_valid,
	output mem_sys_pkg::resp_t resp,
	input logic insn_resp_credit,
	input logic data_resp_credit
);

	import mem_sys_pkg::*;

	logic insn_head_valid;
	insn_req_t insn_head;
	logic insn_pop;
	logic data_head_valid;
	data_req_t data_head;
	logic data_pop;
	logic [1:0] read_room;
	logic cmd_valid;
	ram_cmd_t cmd;
	logic [data_w-1:0] rdata;

	credit_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .item_t(insn_req_t)) insn_q (
		.clk(clk), .rst(rst),
		.in_valid(insn_valid), .in_item(insn_req),
		.head_valid(insn_head_valid), .head_item(insn_head),
		.head_pop(insn_pop), .credit(insn_credit));

	credit_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .item_t(data_req_t)) data_q (
		.clk(clk), .rst(rst),
		.in_valid(data_valid), .in_item(data_req),
		.head_valid(data_head_valid), .head_item(data_head),
		.head_pop(data_pop), .credit(data_credit));

	bus_arbiter arb (
		.clk(clk), .rst(rst),
		.insn_head_valid(insn_head_valid), .insn_head(insn_head),
		.data_head_valid(data_head_valid), .data_head(data_head),
		.read_room(read_room), .insn_pop(insn_pop), .data_pop(data_pop),
		.cmd_valid(cmd_valid), .cmd(cmd));

	block_ram #(.RAM_WORDS(RAM_WORDS)) ram (
		.clk(clk), .cmd_valid(cmd_valid), .cmd(cmd), .rdata(rdata));

	resp_router #(.RESP_CREDITS(RESP_CREDITS)) router (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd(cmd), .rdata(rdata), .read_room(read_room),
		.insn_resp_credit(insn_resp_credit), .data_resp_credit(data_resp_credit),
		.insn_resp_valid(insn_resp_valid), .data_resp_valid(data_resp_valid),
		.resp(resp));

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD = 8.0
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- tb_mem_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_sys;

	import mem_sys_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int RESP_CREDITS = 2;
	localparam int EXP_N = 512;
	localparam int LIMIT = 2000; // Cycles any single wait may take

	logic clk;
	logic rst;
	logic insn_valid;
	insn_req_t insn_req;
	logic insn_credit;
	logic data_valid;
	data_req_t data_req;
	logic data_credit;
	logic insn_resp_valid;
	logic data_resp_valid;
	resp_t resp;
	logic insn_resp_credit;
	logic data_resp_credit;

	logic [data_w-1:0] ref_mem [64];
	logic [data_w-1:0] exp_q [2][EXP_N]; // Expected read words per port in request order
	int exp_wr [2];
	int exp_rd [2];
	int req_cred [2];
	int resp_cred [2]; // Response credits the router may still use
	int owed [2]; // Responses taken but credit not yet handed back
	logic hold [2];
	logic insn_starved;
	int cycle;
	logic [1:0] credit_pulse;
	logic [1:0] resp_pulse;

	tb_clock clk_gen (.clk(clk));

	mem_sys_top dut0 (
		.clk(clk), .rst(rst),
		.insn_valid(insn_valid), .insn_req(insn_req), .insn_credit(insn_credit),
		.data_valid(data_valid), .data_req(data_req), .data_credit(data_credit),
		.insn_resp_valid(insn_resp_valid), .data_resp_valid(data_resp_valid), .resp(resp),
		.insn_resp_credit(insn_resp_credit), .data_resp_credit(data_resp_credit));

	assign credit_pulse = {data_credit, insn_credit};
	assign resp_pulse = {data_resp_valid, insn_resp_valid};

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic wait_request_credit(input int p);
		int guard;
		guard = 0;
		@(negedge clk);
		while (req_cred[p] == 0)
		begin
			guard++;
			if (guard > LIMIT)
				stop_with_failure($sformatf("Timed out waiting for a request credit on port %0d", p));
			else
				@(negedge clk);
		end
	endtask

	task automatic issue_insn(input int word);
		wait_request_credit(PORT_INSN);
		insn_valid = 1'b1;
		insn_req.addr = addr_w'(word * 4);
		req_cred[PORT_INSN]--;
		exp_q[PORT_INSN][exp_wr[PORT_INSN]] = ref_mem[word];
		exp_wr[PORT_INSN]++;
		@(negedge clk);
		insn_valid = 1'b0;
	endtask

	task automatic issue_data(input int word, input logic wr, input logic [data_w-1:0] wdata);
		wait_request_credit(PORT_DATA);
		data_valid = 1'b1;
		data_req.addr = addr_w'(word * 4);
		data_req.wdata = wdata;
		data_req.wr = wr;
		req_cred[PORT_DATA]--;
		if (wr)
			ref_mem[word] = wdata; // Later reads of this word see the new value
		else
		begin
			exp_q[PORT_DATA][exp_wr[PORT_DATA]] = ref_mem[word];
			exp_wr[PORT_DATA]++;
		end
		@(negedge clk);
		data_valid = 1'b0;
	endtask

	task automatic wait_drained(input int p);
		int guard;
		guard = 0;
		while (exp_rd[p] != exp_wr[p] || owed[p] != 0 || req_cred[p] != FIFO_DEPTH)
		begin
			guard++;
			if (guard > LIMIT)
				stop_with_failure($sformatf("Timed out waiting for port %0d to finish", p));
			else
				@(negedge clk);
		end
	endtask

	always @(posedge clk)
	begin
		cycle++;
		if (!rst)
		begin
			for (int p = 0; p < 2; p++)
			begin
				if (credit_pulse[p])
					req_cred[p]++;
				if (resp_pulse[p])
				begin
					exp_rd[p]++;
					owed[p]++;
					resp_cred[p]--;
				end
			end
		end
	end

	// The consumer hands credits back after a random delay unless it is held
	always @(negedge clk)
	begin
		insn_resp_credit = 1'b0;
		data_resp_credit = 1'b0;
		if (!rst && !hold[PORT_INSN] && owed[PORT_INSN] > 0 && $urandom_range(3) != 0)
		begin
			insn_resp_credit = 1'b1;
			owed[PORT_INSN]--;
			resp_cred[PORT_INSN]++;
		end
		if (!rst && !hold[PORT_DATA] && owed[PORT_DATA] > 0 && $urandom_range(3) != 0)
		begin
			data_resp_credit = 1'b1;
			owed[PORT_DATA]--;
			resp_cred[PORT_DATA]++;
		end
	end

	assert property (@(posedge clk) (cycle > 0) && (rst || $past(rst))
		|-> !(insn_resp_valid || data_resp_valid || insn_credit || data_credit))
		else stop_with_failure($sformatf("FAIL %0t: output active during reset", $time));

	assert property (@(posedge clk) disable iff (rst) insn_resp_valid
		|-> exp_rd[0] < exp_wr[0] && resp.rdata == exp_q[0][exp_rd[0]] && resp.port == PORT_INSN)
		else stop_with_failure($sformatf("FAIL %0t: wrong instruction read response", $time));

	assert property (@(posedge clk) disable iff (rst) data_resp_valid
		|-> exp_rd[1] < exp_wr[1] && resp.rdata == exp_q[1][exp_rd[1]] && resp.port == PORT_DATA)
		else stop_with_failure($sformatf("FAIL %0t: wrong data read response", $time));

	assert property (@(posedge clk) disable iff (rst) !(insn_resp_valid && data_resp_valid))
		else stop_with_failure($sformatf("FAIL %0t: two responses in one cycle", $time));

	// A response may only use a credit that the consumer has handed over
	assert property (@(posedge clk) disable iff (rst) insn_resp_valid |-> resp_cred[0] > 0)
		else stop_with_failure($sformatf("FAIL %0t: instruction response without credit", $time));
	assert property (@(posedge clk) disable iff (rst) data_resp_valid |-> resp_cred[1] > 0)
		else stop_with_failure($sformatf("FAIL %0t: data response without credit", $time));

	assert property (@(posedge clk) disable iff (rst) insn_credit |-> req_cred[0] < FIFO_DEPTH)
		else stop_with_failure($sformatf("FAIL %0t: extra instruction request credit", $time));
	assert property (@(posedge clk) disable iff (rst) data_credit |-> req_cred[1] < FIFO_DEPTH)
		else stop_with_failure($sformatf("FAIL %0t: extra data request credit", $time));

	assert property (@(posedge clk) disable iff (rst) insn_starved |-> !insn_credit)
		else stop_with_failure($sformatf("FAIL %0t: credit returned by a stalled queue", $time));

	initial
	begin
		int i;
		void'($urandom(15904));
		rst = 1'b1;
		insn_valid = 1'b0;
		insn_req = '0;
		data_valid = 1'b0;
		data_req = '0;
		insn_resp_credit = 1'b0;
		data_resp_credit = 1'b0;
		insn_starved = 1'b0;
		cycle = 0;
		for (int p = 0; p < 2; p++)
		begin
			exp_wr[p] = 0;
			exp_rd[p] = 0;
			req_cred[p] = FIFO_DEPTH;
			resp_cred[p] = RESP_CREDITS;
			owed[p] = 0;
			hold[p] = 1'b0;
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;

		for (i = 0; i < 64; i++)
			issue_data(i, 1'b1, $urandom);
		for (i = 0; i < 64; i++)
			issue_data(i, 1'b0, '0);
		wait_drained(PORT_DATA);
		for (i = 0; i < 64; i++)
			issue_insn(i);
		wait_drained(PORT_INSN);

		// Starve the fetch consumer so its queue backs up to full
		hold[PORT_INSN] = 1'b1;
		for (i = 0; i < FIFO_DEPTH + RESP_CREDITS; i++)
			issue_insn(i);
		assert (req_cred[PORT_INSN] == 0)
			else stop_with_failure($sformatf("FAIL %0t: instruction queue not full when starved",
				$time));
		insn_starved = 1'b1;
		for (i = 0; i < FIFO_DEPTH; i++)
			issue_data(i, 1'b0, '0);
		wait_drained(PORT_DATA);
		repeat (8) @(negedge clk);
		assert (exp_wr[PORT_INSN] - exp_rd[PORT_INSN] == FIFO_DEPTH)
			else stop_with_failure($sformatf("FAIL %0t: wrong response count under back-pressure",
				$time));
		insn_starved = 1'b0;
		hold[PORT_INSN] = 1'b0;
		wait_drained(PORT_INSN);

		fork
			for (int k = 0; k < 48; k++)
				issue_insn(32 + $urandom_range(31)); // Words the data port no longer writes
			for (int k = 0; k < 48; k++)
				issue_data($urandom_range(31), 1'($urandom_range(1)), $urandom);
		join
		wait_drained(PORT_INSN);
		wait_drained(PORT_DATA);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
mem_sys_pkg.sv
credit_fifo.sv
bus_arbiter.sv
block_ram.sv
resp_router.sv
mem_sys_top.sv
tb_clock.sv
tb_mem_sys.sv

//--- Bender.yml
package:
  name: mem_sys

sources:
  - mem_sys_pkg.sv
  - credit_fifo.sv
  - bus_arbiter.sv
  - block_ram.sv
  - resp_router.sv
  - mem_sys_top.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_mem_sys.sv
